/* Bender.yml */
package:
  name: cache

sources:
  - src/cache_pkg.sv
  - src/cache_way.sv
  - src/cache_mem_port.sv
  - src/cache_ctrl.sv
  - src/cache_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/mem_model.sv
      - bench/cache_tb.sv

/* bench/cache_tests.svh */
localparam logic [29:0] LINE_A = 30'h0000_0105;
localparam logic [29:0] LINE_B = 30'h0000_0207;
localparam logic [29:0] LINE_C = 30'h0000_0309;
localparam logic [29:0] ERR_ADDR = 30'h3fff_0010;

task automatic read_miss_then_hit();
	logic [31:0] val;
	int reads;
	int lat;
	cpu_rsp_t rsp;
	start_test("read miss then hit");
	val = $urandom;
	i_mem.poke(LINE_A, val);
	reads = i_mem.rd_count;
	cpu_access(1'b0, LINE_A, '0, 4'hf, rsp, lat);
	check_rsp("miss response", rsp, good_rsp(val));
	check_count("reads after miss", i_mem.rd_count, reads + 1);
	cpu_access(1'b0, LINE_A, '0, 4'hf, rsp, lat);
	check_rsp("hit response", rsp, good_rsp(val));
	check_count("reads after hit", i_mem.rd_count, reads + 1);
	check_count("hit latency", lat, HIT_LATENCY);
	report_test();
endtask

task automatic write_hit_bytes();
	logic [31:0] old_val;
	logic [31:0] wr_val;
	logic [31:0] thru_old;
	logic [31:0] thru_val;
	int reads;
	int writes;
	int lat;
	cpu_rsp_t rsp;
	start_test("write hit with byte enables");
	old_val = i_mem.peek(LINE_A);
	wr_val = $urandom;
	cpu_access(1'b1, LINE_A, wr_val, 4'b0101, rsp, lat);
	check_flag("write hit error", rsp.error, 1'b0);
	check_count("write hit latency", lat, HIT_LATENCY);
	cpu_access(1'b0, LINE_A, '0, 4'hf, rsp, lat);
	check_rsp("merged read", rsp, good_rsp(merge_bytes(old_val, wr_val, 4'b0101)));
	check_word("memory after write hit", i_mem.peek(LINE_A), old_val);
	// A write miss goes straight to memory, with its own byte select.
	writes = i_mem.wr_count;
	thru_old = i_mem.peek(LINE_B);
	thru_val = $urandom;
	cpu_access(1'b1, LINE_B, thru_val, 4'b0011, rsp, lat);
	check_count("writes after write miss", i_mem.wr_count, writes + 1);
	thru_val = merge_bytes(thru_old, thru_val, 4'b0011);
	check_word("memory after write miss", i_mem.peek(LINE_B), thru_val);
	reads = i_mem.rd_count;
	cpu_access(1'b0, LINE_B, '0, 4'hf, rsp, lat);
	check_count("reads after write miss", i_mem.rd_count, reads + 1);
	check_rsp("read after write miss", rsp, good_rsp(thru_val));
	report_test();
endtask

task automatic flush_dirty_lines();
	logic [29:0] addrs [3];
	logic [31:0] vals [3];
	int reads;
	int writes;
	int lat;
	cpu_rsp_t rsp;
	start_test("flush");
	addrs[0] = LINE_A;
	addrs[1] = LINE_B;
	addrs[2] = LINE_C;
	for (int i = 0; i < 3; i++) begin
		vals[i] = $urandom;
		cpu_access(1'b0, addrs[i], '0, 4'hf, rsp, lat);
		cpu_access(1'b1, addrs[i], vals[i], 4'hf, rsp, lat);
	end
	writes = i_mem.wr_count;
	run_maint(1'b1);
	check_count("writebacks during flush", i_mem.wr_count, writes + 3);
	reads = i_mem.rd_count;
	writes = i_mem.wr_count;
	for (int i = 0; i < 3; i++) begin
		check_word("memory after flush", i_mem.peek(addrs[i]), vals[i]);
		cpu_access(1'b0, addrs[i], '0, 4'hf, rsp, lat);
		check_rsp("read after flush", rsp, good_rsp(vals[i]));
		check_count("latency after flush", lat, HIT_LATENCY);
	end
	check_count("reads after flush", i_mem.rd_count, reads);
	check_count("writes after flush", i_mem.wr_count, writes);
	report_test();
endtask

task automatic evict_round_robin();
	logic [29:0] addrs [3];
	logic [31:0] vals [3];
	logic [31:0] dirty_val;
	int reads;
	int writes;
	int lat;
	cpu_rsp_t rsp;
	start_test("round robin eviction");
	// Three tags on index 11.
	addrs[0] = 30'h0000_040b;
	addrs[1] = 30'h0000_050b;
	addrs[2] = 30'h0000_060b;
	for (int i = 0; i < 3; i++) begin
		vals[i] = $urandom;
		i_mem.poke(addrs[i], vals[i]);
	end
	cpu_access(1'b0, addrs[0], '0, 4'hf, rsp, lat);
	check_rsp("first fill", rsp, good_rsp(vals[0]));
	dirty_val = $urandom;
	cpu_access(1'b1, addrs[0], dirty_val, 4'hf, rsp, lat);
	cpu_access(1'b0, addrs[1], '0, 4'hf, rsp, lat);
	check_rsp("second fill", rsp, good_rsp(vals[1]));
	reads = i_mem.rd_count;
	writes = i_mem.wr_count;
	cpu_access(1'b0, addrs[2], '0, 4'hf, rsp, lat);
	check_rsp("replacing fill", rsp, good_rsp(vals[2]));
	check_count("writebacks on eviction", i_mem.wr_count, writes + 1);
	check_count("reads on eviction", i_mem.rd_count, reads + 1);
	check_word("evicted line in memory", i_mem.peek(addrs[0]), dirty_val);
	check_flag("writeback before fill", i_mem.prev_we, 1'b1);
	check_word("writeback address", {2'b00, i_mem.prev_addr}, {2'b00, addrs[0]});
	check_word("fill address", {2'b00, i_mem.last_addr}, {2'b00, addrs[2]});
	cpu_access(1'b0, addrs[1], '0, 4'hf, rsp, lat);
	check_rsp("kept line", rsp, good_rsp(vals[1]));
	check_count("kept line latency", lat, HIT_LATENCY);
	reads = i_mem.rd_count;
	cpu_access(1'b0, addrs[0], '0, 4'hf, rsp, lat);
	check_count("reads of evicted line", i_mem.rd_count, reads + 1);
	check_rsp("evicted line refetch", rsp, good_rsp(dirty_val));
	report_test();
endtask

task automatic bypass_and_errors();
	logic [29:0] addr;
	logic [31:0] val;
	logic [31:0] wr_val;
	int reads;
	int writes;
	int lat;
	cpu_rsp_t rsp;
	start_test("bypass and memory errors");
	addr = 30'h0000_0701;
	val = $urandom;
	i_mem.poke(addr, val);
	enabled = 1'b0;
	reads = i_mem.rd_count;
	for (int i = 0; i < 2; i++) begin
		cpu_access(1'b0, addr, '0, 4'hf, rsp, lat);
		check_rsp("read with cache disabled", rsp, good_rsp(val));
	end
	check_count("reads with cache disabled", i_mem.rd_count, reads + 2);
	writes = i_mem.wr_count;
	wr_val = $urandom;
	cpu_access(1'b1, addr, wr_val, 4'hf, rsp, lat);
	check_count("writes with cache disabled", i_mem.wr_count, writes + 1);
	check_word("memory after bypass write", i_mem.peek(addr), wr_val);
	enabled = 1'b1;
	cacheable = 1'b0;
	reads = i_mem.rd_count;
	for (int i = 0; i < 2; i++) begin
		cpu_access(1'b0, addr, '0, 4'hf, rsp, lat);
		check_rsp("read not cacheable", rsp, good_rsp(wr_val));
	end
	check_count("reads not cacheable", i_mem.rd_count, reads + 2);
	cacheable = 1'b1;
	reads = i_mem.rd_count;
	cpu_access(1'b0, addr, '0, 4'hf, rsp, lat);
	check_count("reads after bypass", i_mem.rd_count, reads + 1);
	check_rsp("read after bypass", rsp, good_rsp(wr_val));
	reads = i_mem.rd_count;
	for (int i = 0; i < 2; i++) begin
		cpu_access(1'b0, ERR_ADDR, '0, 4'hf, rsp, lat);
		check_flag("error in error window", rsp.error, 1'b1);
	end
	check_count("reads in error window", i_mem.rd_count, reads + 2);
	report_test();
endtask

task automatic invalidate_dirty_line();
	logic [29:0] addr;
	logic [31:0] old_val;
	logic [31:0] new_val;
	int reads;
	int writes;
	int lat;
	cpu_rsp_t rsp;
	start_test("invalidate");
	addr = 30'h0000_0803;
	old_val = $urandom;
	i_mem.poke(addr, old_val);
	cpu_access(1'b0, addr, '0, 4'hf, rsp, lat);
	check_rsp("fill before invalidate", rsp, good_rsp(old_val));
	new_val = $urandom;
	cpu_access(1'b1, addr, new_val, 4'hf, rsp, lat);
	check_flag("dirty write error", rsp.error, 1'b0);
	writes = i_mem.wr_count;
	run_maint(1'b0);
	check_count("writes during invalidate", i_mem.wr_count, writes);
	reads = i_mem.rd_count;
	cpu_access(1'b0, addr, '0, 4'hf, rsp, lat);
	check_count("reads after invalidate", i_mem.rd_count, reads + 1);
	check_rsp("read after invalidate", rsp, good_rsp(old_val));
	check_word("memory after invalidate", i_mem.peek(addr), old_val);
	report_test();
endtask

/* bench/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;
	import cache_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES = 400;
	localparam int HIT_LATENCY = 2;

	logic clk;
	logic reset;
	logic enabled;
	logic cacheable;
	logic flush;
	logic inval;
	logic maint_done;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;
	mem_req_t mem_req;
	logic [31:0] mem_data;
	logic mem_ack;
	logic mem_error;

	int checks;
	int errors;
	int tests_done;
	int errors_at_start;
	string test_name;

	cache_top i_cache_top (
		.clk        (clk),
		.reset      (reset),
		.enabled    (enabled),
		.cacheable  (cacheable),
		.flush      (flush),
		.inval      (inval),
		.cpu_req    (cpu_req),
		.cpu_rsp    (cpu_rsp),
		.mem_req    (mem_req),
		.mem_data   (mem_data),
		.mem_ack    (mem_ack),
		.mem_error  (mem_error),
		.maint_done (maint_done)
	);

	mem_model i_mem (
		.clk       (clk),
		.reset     (reset),
		.mem_req   (mem_req),
		.mem_data  (mem_data),
		.mem_ack   (mem_ack),
		.mem_error (mem_error)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("Watchdog expired with %0d of %0d tests finished", tests_done, NUM_TESTS);
		$display("TESTS FAILED");
		$finish;
	end

	task automatic check_rsp(input string name, input cpu_rsp_t got, input cpu_rsp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got ack=%b error=%b data=%h, expected ack=%b error=%b data=%h",
				$time, name, got.ack, got.error, got.data, exp.ack, exp.error, exp.data);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	function automatic cpu_rsp_t good_rsp(input logic [31:0] data);
		cpu_rsp_t rsp;
		rsp.ack = 1'b1;
		rsp.error = 1'b0;
		rsp.data = data;
		return rsp;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] sel);
		logic [31:0] word;
		word = old_val;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				word[b*8 +: 8] = new_val[b*8 +: 8];
		end
		return word;
	endfunction

	// Starts at a drive point and returns at the drive point after ack.
	task automatic cpu_access(input logic wr, input logic [29:0] addr, input logic [31:0] val,
		input logic [3:0] sel, output cpu_rsp_t rsp, output int latency);
		latency = 0;
		rsp = '0;
		cpu_req.access = 1'b1;
		cpu_req.wr_en = wr;
		cpu_req.addr.raw = addr;
		cpu_req.wr_val = val;
		cpu_req.bytesel = sel;
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
			cpu_req.access = 1'b0;
			latency++;
		end while (!cpu_rsp.ack && latency < TEST_CYCLES);
		if (cpu_rsp.ack) begin
			rsp = cpu_rsp;
		end else begin
			errors++;
			$display("Access to address %h got no ack within %0d cycles", addr, TEST_CYCLES);
		end
	endtask

	task automatic run_maint(input logic do_flush);
		int cycles;
		cycles = 0;
		flush = do_flush;
		inval = !do_flush;
		@(posedge clk);
		#DRIVE_DELAY;
		flush = 1'b0;
		inval = 1'b0;
		while (!maint_done && cycles < TEST_CYCLES) begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
		end
		if (!maint_done) begin
			errors++;
			$display("Maintenance walk did not signal done within %0d cycles", TEST_CYCLES);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic report_test();
		tests_done++;
		if (errors == errors_at_start)
			$display("%s: ok", test_name);
		else
			$display("%s: %0d errors", test_name, errors - errors_at_start);
	endtask

	`include "cache_tests.svh"

	initial begin
		void'($urandom(32'hb23ab389));
		checks = 0;
		errors = 0;
		tests_done = 0;
		reset = 1'b1;
		enabled = 1'b1;
		cacheable = 1'b1;
		flush = 1'b0;
		inval = 1'b0;
		cpu_req = '0;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		read_miss_then_hit();
		write_hit_bytes();
		flush_dirty_lines();
		evict_round_robin();
		bypass_and_errors();
		invalidate_dirty_line();

		$display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* bench/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
	input  logic                clk,
	input  logic                reset,
	input  cache_pkg::mem_req_t mem_req,
	output logic [31:0]         mem_data,
	output logic                mem_ack,
	output logic                mem_error
);
	import cache_pkg::*;

	localparam int WAIT_CYCLES = 4;
	localparam logic [ADDR_BITS-1:0] ERR_BASE = 30'h3fff_0000;

	logic [31:0] words [logic [ADDR_BITS-1:0]];
	logic [31:0] merged;
	int wait_cnt;
	int rd_count;
	int wr_count;
	// Two most recent accesses, the newest in last_*.
	logic prev_we;
	logic last_we;
	logic [ADDR_BITS-1:0] prev_addr;
	logic [ADDR_BITS-1:0] last_addr;

	// Words never written read as a pattern of their full address.
	function automatic logic [31:0] peek(input logic [ADDR_BITS-1:0] addr);
		if (words.exists(addr))
			return words[addr];
		return {addr[13:0], addr[29:12]} ^ 32'h5a3c_96e1;
	endfunction

	function automatic void poke(input logic [ADDR_BITS-1:0] addr, input logic [31:0] val);
		words[addr] = val;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			mem_ack <= 1'b0;
			mem_error <= 1'b0;
			mem_data <= '0;
			wait_cnt = 0;
			rd_count = 0;
			wr_count = 0;
			prev_we = 1'b0;
			last_we = 1'b0;
			prev_addr = '0;
			last_addr = '0;
		end else begin
			mem_ack <= 1'b0;
			if (mem_req.access && !mem_ack) begin
				if (wait_cnt < WAIT_CYCLES) begin
					wait_cnt++;
				end else begin
					wait_cnt = 0;
					mem_ack <= 1'b1;
					mem_error <= (mem_req.addr >= ERR_BASE);
					mem_data <= '0;
					prev_we = last_we;
					prev_addr = last_addr;
					last_we = mem_req.wr_en;
					last_addr = mem_req.addr;
					if (mem_req.wr_en) begin
						wr_count++;
						merged = peek(mem_req.addr);
						for (int b = 0; b < 4; b++) begin
							if (mem_req.bytesel[b])
								merged[b*8 +: 8] = mem_req.wr_val[b*8 +: 8];
						end
						if (mem_req.addr < ERR_BASE)
							words[mem_req.addr] = merged;
					end else begin
						rd_count++;
						if (mem_req.addr < ERR_BASE)
							mem_data <= peek(mem_req.addr);
					end
				end
			end
		end
	end

endmodule

/* sources.f */
+incdir+bench
src/cache_pkg.sv
src/cache_way.sv
src/cache_mem_port.sv
src/cache_ctrl.sv
src/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv

/* src/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 enabled,
	input  logic                 cacheable,
	input  logic                 flush,
	input  logic                 inval,
	input  cache_pkg::cpu_req_t  cpu_req,
	output cache_pkg::cpu_rsp_t  cpu_rsp,
	output cache_pkg::way_cmd_t  way_cmd [cache_pkg::NUM_WAYS],
	input  cache_pkg::way_stat_t way_stat [cache_pkg::NUM_WAYS],
	output logic                 mem_start,
	output cache_pkg::mem_req_t  mem_req,
	input  logic                 mem_done,
	input  logic [31:0]          mem_rdata,
	input  logic                 mem_error,
	output logic                 maint_done
);
	import cache_pkg::*;

	typedef enum logic [2:0] {
		IDLE, LOOKUP, BYPASS, WTHRU, WRBACK, FILL, RESPOND, WALK
	} state_e;

	state_e state, next_state;
	cpu_req_t req_q;
	logic [WAY_BITS-1:0] victim;
	logic [WAY_BITS-1:0] hit_way;
	logic [WAY_BITS-1:0] walk_way;
	logic [INDEX_BITS-1:0] walk_idx;
	logic [NUM_WAYS-1:0] hit_vec;
	logic walk_active, walk_flush, walk_stat, walk_last;
	logic flush_pend, inval_pend;
	logic hit_ack, walk_adv;
	way_stat_t vstat, wstat;

	always_comb begin
		hit_vec = '0;
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_vec[w] = way_stat[w].hit;
			if (way_stat[w].hit)
				hit_way = WAY_BITS'(w);
		end
	end

	assign vstat = way_stat[victim];
	assign wstat = way_stat[walk_way];
	assign walk_last = (walk_way == WAY_BITS'(NUM_WAYS - 1)) && (&walk_idx);

	always_comb begin
		next_state = state;
		mem_start = 1'b0;
		mem_req.access = 1'b1;
		mem_req.wr_en = req_q.wr_en;
		mem_req.addr = req_q.addr.raw;
		mem_req.wr_val = req_q.wr_val;
		mem_req.bytesel = req_q.bytesel;
		hit_ack = 1'b0;
		walk_adv = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_cmd[w].op = WAY_NONE;
			way_cmd[w].index = (state == IDLE) ? cpu_req.addr.ti.index : req_q.addr.ti.index;
			way_cmd[w].tag = (state == IDLE) ? cpu_req.addr.ti.tag : req_q.addr.ti.tag;
			way_cmd[w].data = (state == FILL) ? mem_rdata : req_q.wr_val;
			way_cmd[w].bytesel = req_q.bytesel;
			if (state == WALK || (state == WRBACK && walk_active))
				way_cmd[w].index = walk_idx;
		end

		case (state)
		IDLE: begin
			if (cpu_req.access && (!enabled || !cacheable)) begin
				mem_start = 1'b1;
				mem_req.wr_en = cpu_req.wr_en;
				mem_req.addr = cpu_req.addr.raw;
				mem_req.wr_val = cpu_req.wr_val;
				mem_req.bytesel = cpu_req.bytesel;
				next_state = BYPASS;
			end else if (cpu_req.access) begin
				for (int w = 0; w < NUM_WAYS; w++)
					way_cmd[w].op = WAY_LOOKUP;
				next_state = LOOKUP;
			end else if (flush_pend || inval_pend) begin
				next_state = WALK;
			end
		end
		LOOKUP: begin
			if (|hit_vec) begin
				hit_ack = 1'b1;
				if (req_q.wr_en)
					way_cmd[hit_way].op = WAY_WRITE;
				next_state = IDLE;
			end else if (req_q.wr_en) begin
				mem_start = 1'b1;
				next_state = WTHRU;
			end else if (vstat.valid && vstat.dirty) begin
				// Victim goes back to memory first.
				mem_start = 1'b1;
				mem_req.wr_en = 1'b1;
				mem_req.addr = {vstat.tag, req_q.addr.ti.index};
				mem_req.wr_val = vstat.data;
				mem_req.bytesel = 4'hf;
				next_state = WRBACK;
			end else begin
				mem_start = 1'b1;
				mem_req.wr_en = 1'b0;
				mem_req.bytesel = 4'hf;
				next_state = FILL;
			end
		end
		BYPASS, WTHRU: begin
			if (mem_done)
				next_state = RESPOND;
		end
		WRBACK: begin
			if (mem_done && walk_active) begin
				if (!mem_error)
					way_cmd[walk_way].op = WAY_CLEAN;
				walk_adv = 1'b1;
				next_state = walk_last ? IDLE : WALK;
			end else if (mem_done && mem_error) begin
				next_state = RESPOND;
			end else if (mem_done) begin
				way_cmd[victim].op = WAY_CLEAN;
				mem_start = 1'b1;
				mem_req.wr_en = 1'b0;
				mem_req.bytesel = 4'hf;
				next_state = FILL;
			end
		end
		FILL: begin
			if (mem_done) begin
				if (!mem_error)
					way_cmd[victim].op = WAY_FILL;
				next_state = RESPOND;
			end
		end
		RESPOND: begin
			next_state = IDLE;
		end
		WALK: begin
			if (!walk_stat && walk_flush) begin
				way_cmd[walk_way].op = WAY_LOOKUP;
			end else if (!walk_stat) begin
				way_cmd[walk_way].op = WAY_INVAL;
				walk_adv = 1'b1;
			end else if (wstat.valid && wstat.dirty) begin
				mem_start = 1'b1;
				mem_req.wr_en = 1'b1;
				mem_req.addr = {wstat.tag, walk_idx};
				mem_req.wr_val = wstat.data;
				mem_req.bytesel = 4'hf;
				next_state = WRBACK;
			end else begin
				walk_adv = 1'b1;
			end
			if (walk_adv && walk_last)
				next_state = IDLE;
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			victim <= '0;
			walk_active <= 1'b0;
			walk_flush <= 1'b0;
			walk_stat <= 1'b0;
			walk_way <= '0;
			walk_idx <= '0;
			flush_pend <= 1'b0;
			inval_pend <= 1'b0;
			maint_done <= 1'b0;
			cpu_rsp.ack <= 1'b0;
		end else begin
			state <= next_state;
			maint_done <= walk_adv && walk_last;
			cpu_rsp.ack <= hit_ack || (state == RESPOND);
			if (hit_ack) begin
				cpu_rsp.error <= 1'b0;
				cpu_rsp.data <= way_stat[hit_way].data;
			end else if (state == RESPOND) begin
				cpu_rsp.error <= mem_error;
				cpu_rsp.data <= mem_rdata;
			end
			if (state == IDLE && cpu_req.access)
				req_q <= cpu_req;
			if (state == FILL && mem_done && !mem_error)
				victim <= victim + 1'b1;

			// Flush runs ahead of invalidate when both wait.
			if (state == IDLE && next_state == WALK) begin
				walk_active <= 1'b1;
				walk_flush <= flush_pend;
				walk_stat <= 1'b0;
				walk_way <= '0;
				walk_idx <= '0;
				if (flush_pend)
					flush_pend <= 1'b0;
				else
					inval_pend <= 1'b0;
			end
			if (state == WALK && !walk_stat && walk_flush)
				walk_stat <= 1'b1;
			if (walk_adv) begin
				walk_stat <= 1'b0;
				walk_idx <= walk_idx + 1'b1;
				if (&walk_idx)
					walk_way <= walk_way + 1'b1;
				if (walk_last)
					walk_active <= 1'b0;
			end
			if (flush)
				flush_pend <= 1'b1;
			if (inval)
				inval_pend <= 1'b1;
		end
	end

	one_hit: assert property (@(posedge clk) disable iff (reset)
		state == LOOKUP |-> $onehot0(hit_vec));

	ack_pulse: assert property (@(posedge clk) disable iff (reset)
		cpu_rsp.ack |=> !cpu_rsp.ack);

endmodule

/* src/cache_mem_port.sv */
`timescale 1ns/1ps

module cache_mem_port (
	input  logic                clk,
	input  logic                reset,
	input  logic                start,
	input  cache_pkg::mem_req_t req,
	output cache_pkg::mem_req_t mem_req,
	input  logic [31:0]         mem_data,
	input  logic                mem_ack,
	input  logic                mem_error,
	output logic                done,
	output logic [31:0]         rdata,
	output logic                error
);
	import cache_pkg::*;

	mem_req_t req_q;
	logic busy;

	// The bus level drops in the acknowledge cycle.
	always_comb begin
		mem_req = req_q;
		mem_req.access = busy && !mem_ack;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= busy && mem_ack;
			if (start)
				busy <= req.access;
			else if (mem_ack)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			req_q <= req;
		if (busy && mem_ack) begin
			rdata <= mem_data;
			error <= mem_error;
		end
	end

	// The controller only starts a transfer once the previous one is done.
	no_overlap: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

/* src/cache_pkg.sv */
package cache_pkg;

	localparam int ADDR_BITS = 30;
	localparam int NUM_WAYS = 2;
	localparam int WAY_BITS = $clog2(NUM_WAYS);
	localparam int INDEX_BITS = 4;
	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_BITS = ADDR_BITS - INDEX_BITS;

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [INDEX_BITS-1:0] index;
	} tag_index_t;

	// Memory sees the raw word address, the ways see tag and index.
	typedef union packed {
		logic [ADDR_BITS-1:0] raw;
		tag_index_t ti;
	} word_addr_u;

	typedef struct packed {
		logic access;
		logic wr_en;
		word_addr_u addr;
		logic [31:0] wr_val;
		logic [3:0] bytesel;
	} cpu_req_t;

	typedef struct packed {
		logic ack;
		logic error;
		logic [31:0] data;
	} cpu_rsp_t;

	typedef struct packed {
		logic access;
		logic wr_en;
		logic [ADDR_BITS-1:0] addr;
		logic [31:0] wr_val;
		logic [3:0] bytesel;
	} mem_req_t;

	typedef enum logic [2:0] {
		WAY_NONE,
		WAY_LOOKUP,
		WAY_WRITE,
		WAY_FILL,
		WAY_CLEAN,
		WAY_INVAL
	} way_op_e;

	typedef struct packed {
		way_op_e op;
		logic [INDEX_BITS-1:0] index;
		logic [TAG_BITS-1:0] tag;
		logic [31:0] data;
		logic [3:0] bytesel;
	} way_cmd_t;

	typedef struct packed {
		logic hit;
		logic valid;
		logic dirty;
		logic [TAG_BITS-1:0] tag;
		logic [31:0] data;
	} way_stat_t;

endpackage

/* src/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                enabled,
	input  logic                cacheable,
	input  logic                flush,
	input  logic                inval,
	input  cache_pkg::cpu_req_t cpu_req,
	output cache_pkg::cpu_rsp_t cpu_rsp,
	output cache_pkg::mem_req_t mem_req,
	input  logic [31:0]         mem_data,
	input  logic                mem_ack,
	input  logic                mem_error,
	output logic                maint_done
);
	import cache_pkg::*;

	way_cmd_t way_cmd [NUM_WAYS];
	way_stat_t way_stat [NUM_WAYS];
	mem_req_t port_req;
	logic port_start;
	logic port_done;
	logic [31:0] port_rdata;
	logic port_error;

	cache_ctrl i_ctrl (
		.clk        (clk),
		.reset      (reset),
		.enabled    (enabled),
		.cacheable  (cacheable),
		.flush      (flush),
		.inval      (inval),
		.cpu_req    (cpu_req),
		.cpu_rsp    (cpu_rsp),
		.way_cmd    (way_cmd),
		.way_stat   (way_stat),
		.mem_start  (port_start),
		.mem_req    (port_req),
		.mem_done   (port_done),
		.mem_rdata  (port_rdata),
		.mem_error  (port_error),
		.maint_done (maint_done)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
		cache_way i_way (
			.clk   (clk),
			.reset (reset),
			.cmd   (way_cmd[w]),
			.stat  (way_stat[w])
		);
	end

	cache_mem_port i_mem_port (
		.clk       (clk),
		.reset     (reset),
		.start     (port_start),
		.req       (port_req),
		.mem_req   (mem_req),
		.mem_data  (mem_data),
		.mem_ack   (mem_ack),
		.mem_error (mem_error),
		.done      (port_done),
		.rdata     (port_rdata),
		.error     (port_error)
	);

endmodule

/* src/cache_way.sv */
`timescale 1ns/1ps

module cache_way (
	input  logic                 clk,
	input  logic                 reset,
	input  cache_pkg::way_cmd_t  cmd,
	output cache_pkg::way_stat_t stat
);
	import cache_pkg::*;

	logic [TAG_BITS-1:0] tag_mem [LINES];
	logic [31:0] data_mem [LINES];
	logic [LINES-1:0] valid;
	logic [LINES-1:0] dirty;
	logic [31:0] merged;

	// Byte merge of the write value into the stored word.
	always_comb begin
		merged = data_mem[cmd.index];
		for (int b = 0; b < 4; b++) begin
			if (cmd.bytesel[b])
				merged[b*8 +: 8] = cmd.data[b*8 +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
		end else begin
			case (cmd.op)
			WAY_WRITE: begin
				dirty[cmd.index] <= 1'b1;
			end
			WAY_FILL: begin
				valid[cmd.index] <= 1'b1;
				dirty[cmd.index] <= 1'b0;
			end
			WAY_CLEAN: begin
				dirty[cmd.index] <= 1'b0;
			end
			WAY_INVAL: begin
				valid[cmd.index] <= 1'b0;
				dirty[cmd.index] <= 1'b0;
			end
			default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.op == WAY_FILL) begin
			tag_mem[cmd.index] <= cmd.tag;
			data_mem[cmd.index] <= cmd.data;
		end else if (cmd.op == WAY_WRITE) begin
			data_mem[cmd.index] <= merged;
		end
	end

	// Status of the indexed line, valid the cycle after a lookup.
	always_ff @(posedge clk) begin
		if (reset) begin
			stat.hit <= 1'b0;
		end else if (cmd.op == WAY_LOOKUP) begin
			stat.hit <= valid[cmd.index] && (tag_mem[cmd.index] == cmd.tag);
			stat.valid <= valid[cmd.index];
			stat.dirty <= dirty[cmd.index];
			stat.tag <= tag_mem[cmd.index];
			stat.data <= data_mem[cmd.index];
		end
	end

	// A dirty line must be written back and cleaned before it is refilled.
	fill_not_dirty: assert property (@(posedge clk) disable iff (reset)
		cmd.op == WAY_FILL |-> !(valid[cmd.index] && dirty[cmd.index]));

endmodule
